/* ls_pkg.sv */
//////////////////////////////
// Load/store types, function codes, address map and sizing constants
//////////////////////////////
`default_nettype none

package ls_pkg;

    // Width codes, RISC-V encoding
    // Stores only use the low two bits
    typedef enum logic [2:0] {
        LS_B  = 3'b000,
        LS_H  = 3'b001,
        LS_W  = 3'b010,
        LS_BU = 3'b100,
        LS_HU = 3'b101
    } ls_fn3_e;

    typedef logic [3:0] ls_id_t;

    // Address map
    localparam logic [31:0] SCRATCH_BASE  = 32'h0000_0000;
    localparam int          SCRATCH_WORDS = 1024;
    localparam logic [31:0] SLOW_BASE     = 32'h0001_0000;
    localparam int          SLOW_WORDS    = 256;

    // Word index width, sized by the larger region
    localparam int WORD_ADDR_W = $clog2(SCRATCH_WORDS);

    localparam int SLOW_WAIT_CYCLES = 3;
    localparam int INPUT_DEPTH      = 4;
    localparam int ATTR_DEPTH       = 2;

    // Sub-unit indices
    localparam int NUM_UNITS   = 2;
    localparam int UNIT_IDX_W  = $clog2(NUM_UNITS);
    localparam int SCRATCH_ID  = 0;
    localparam int SLOW_ID     = 1;

    // Request as queued in the input buffer
    typedef struct packed {
        logic        store;
        ls_fn3_e     fn3;
        logic [31:0] addr;
        logic [31:0] wdata;
        ls_id_t      id;
    } ls_request_t;

    // Kept per issued request until completion
    typedef struct packed {
        ls_fn3_e    fn3;
        logic [1:0] byte_addr;
        ls_id_t     id;
        logic       store;
        logic       error;
    } load_attr_t;

    // Request as seen by each sub-unit
    typedef struct packed {
        logic [WORD_ADDR_W-1:0] word_addr;
        logic                   store;
        logic [3:0]             be;
        logic [31:0]            wdata;
    } sub_unit_req_t;

endpackage

`default_nettype wire

/* ls_sub_unit_if.sv */
//////////////////////////////
// Core to memory sub-unit link
//////////////////////////////
`default_nettype none

interface ls_sub_unit_if import ls_pkg::*; ();

    sub_unit_req_t req;
    logic          new_request;
    logic          ready;
    logic          data_valid;
    logic [31:0]   data_out;

    // Unit core side, one instance per sub-unit
    modport core (
        output req, new_request,
        input  ready, data_valid, data_out
    );

    // Memory side
    modport unit (
        input  req, new_request,
        output ready, data_valid, data_out
    );

endinterface

`default_nettype wire

/* ls_fifo.sv */
//////////////////////////////
// Circular queue for any payload type
//////////////////////////////
`default_nettype none

module ls_fifo #(
    parameter type item_t = logic,
    parameter int  DEPTH  = 2
) (
    input  wire logic  clk,
    input  wire logic  rst,
    input  wire logic  push,
    input  wire logic  pop,
    input  wire item_t data_in,
    output item_t      data_out,
    output logic       valid,
    output logic       full,
    output logic       empty
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    item_t            mem [DEPTH];
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;
    logic [CNT_W-1:0] count;
    logic             do_push;
    logic             do_pop;

    // Push into a full queue is dropped
    assign do_push = push & ~full;
    assign do_pop  = pop & ~empty;

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push)
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (do_pop)
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Storage
    always_ff @(posedge clk) begin
        if (do_push)
            mem[wr_ptr] <= data_in;
    end

    assign data_out = mem[rd_ptr];
    assign empty    = (count == '0);
    assign full     = (count == CNT_W'(DEPTH));
    assign valid    = ~empty;

endmodule

`default_nettype wire

/* scratch_mem.sv */
//////////////////////////////
// Single-cycle scratch memory sub-unit
//////////////////////////////
`default_nettype none

module scratch_mem import ls_pkg::*; (
    input wire logic clk,
    input wire logic rst,
    ls_sub_unit_if.unit ls
);

    localparam int IDX_W = $clog2(SCRATCH_WORDS);

    logic [31:0]      mem [SCRATCH_WORDS];
    logic [31:0]      rdata;
    logic             rvalid;
    logic [IDX_W-1:0] idx;

    assign idx = ls.req.word_addr[IDX_W-1:0];

    // Byte-enabled write, registered read
    always_ff @(posedge clk) begin
        if (ls.new_request) begin
            if (ls.req.store) begin
                for (int i = 0; i < 4; i++) begin
                    if (ls.req.be[i])
                        mem[idx][8*i +: 8] <= ls.req.wdata[8*i +: 8];
                end
            end else begin
                rdata <= mem[idx];
            end
        end
    end

    // Load data valid one cycle after the request
    always_ff @(posedge clk) begin
        if (rst)
            rvalid <= 1'b0;
        else
            rvalid <= ls.new_request & ~ls.req.store;
    end

    // Never busy
    assign ls.ready      = 1'b1;
    assign ls.data_valid = rvalid;
    // Zero when idle so the core can OR units together
    assign ls.data_out   = rvalid ? rdata : 32'h0;

endmodule

`default_nettype wire

/* wait_timer.sv */
//////////////////////////////
// Wait state down-counter
//////////////////////////////
`default_nettype none

module wait_timer import ls_pkg::*; (
    input  wire logic clk,
    input  wire logic rst,
    input  wire logic start,
    output logic      done
);

    localparam int CNT_W = $clog2(SLOW_WAIT_CYCLES + 1);

    logic [CNT_W-1:0] count;
    logic             busy;

    // Count holds the wait cycles left after the current one
    always_ff @(posedge clk) begin
        if (rst) begin
            count <= '0;
            busy  <= 1'b0;
        end else if (start) begin
            count <= CNT_W'(SLOW_WAIT_CYCLES - 1);
            busy  <= 1'b1;
        end else if (busy) begin
            if (count == '0)
                busy <= 1'b0;
            else
                count <= count - 1'b1;
        end
    end

    // High during the last wait cycle
    assign done = busy & (count == '0);

endmodule

`default_nettype wire

/* slow_mem_ctrl.sv */
//////////////////////////////
// Slow memory sub-unit with fixed wait states
//////////////////////////////
`default_nettype none

module slow_mem_ctrl import ls_pkg::*; (
    input wire logic clk,
    input wire logic rst,
    ls_sub_unit_if.unit ls
);

    localparam int IDX_W = $clog2(SLOW_WORDS);

    typedef enum logic [1:0] {
        IDLE,
        WAIT,
        RESPOND
    } state_e;

    state_e           state;
    state_e           next_state;
    sub_unit_req_t    req_q;
    logic [31:0]      mem [SLOW_WORDS];
    logic [IDX_W-1:0] idx;
    logic             accept;
    logic             timer_done;

    // Busy only while waiting
    assign ls.ready = (state != WAIT);
    assign accept   = ls.new_request & ls.ready;
    assign idx      = req_q.word_addr[IDX_W-1:0];

    wait_timer i_wait_timer (
        .clk   (clk),
        .rst   (rst),
        .start (accept),
        .done  (timer_done)
    );

    //////////////////////////////
    // State machine
    always_comb begin
        next_state = state;
        case (state)
            IDLE:    if (accept) next_state = WAIT;
            WAIT:    if (timer_done) next_state = RESPOND;
            // Back-to-back accept from respond
            RESPOND: next_state = accept ? WAIT : IDLE;
            default: next_state = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst)
            state <= IDLE;
        else
            state <= next_state;
    end

    // Request latch
    always_ff @(posedge clk) begin
        if (accept)
            req_q <= ls.req;
    end

    //////////////////////////////
    // Array access in respond
    always_ff @(posedge clk) begin
        if (state == RESPOND && req_q.store) begin
            for (int i = 0; i < 4; i++) begin
                if (req_q.be[i])
                    mem[idx][8*i +: 8] <= req_q.wdata[8*i +: 8];
            end
        end
    end

    assign ls.data_valid = (state == RESPOND) & ~req_q.store;
    assign ls.data_out   = ls.data_valid ? mem[idx] : 32'h0;

endmodule

`default_nettype wire

/* load_store_unit.sv */
//////////////////////////////
// Load/store unit core: queueing, issue, byte lanes, load return
//////////////////////////////
`default_nettype none

module load_store_unit import ls_pkg::*; (
    input  wire logic         clk,
    input  wire logic         rst,
    input  wire logic         req_valid,
    output logic              req_ready,
    input  wire ls_request_t  req,
    ls_sub_unit_if.core       scratch,
    ls_sub_unit_if.core       slow,
    output logic              resp_valid,
    output ls_id_t            resp_id,
    output logic [31:0]       resp_data,
    output logic              resp_error
);

    ls_request_t           head;
    logic                  head_valid;
    logic                  in_full;
    logic                  misaligned;
    logic                  scratch_hit;
    logic                  slow_hit;
    logic                  error;
    logic [31:0]           offset;
    logic [UNIT_IDX_W-1:0] target_unit;
    logic [UNIT_IDX_W-1:0] last_unit;
    logic [NUM_UNITS-1:0]  unit_ready;
    logic                  unit_stall;
    logic                  issue;
    logic [3:0]            be;
    logic [31:0]           lane_data;
    sub_unit_req_t         unit_req;
    load_attr_t            attr_in;
    load_attr_t            attr_head;
    logic                  attr_valid;
    logic                  attr_empty;
    logic                  load_complete;
    logic [31:0]           unit_data;
    logic [31:0]           aligned;
    logic [31:0]           final_data;

    //////////////////////////////
    // Input buffer
    ls_fifo #(.item_t(ls_request_t), .DEPTH(INPUT_DEPTH)) i_input_fifo (
        .clk(clk), .rst(rst),
        .push(req_valid & req_ready), .pop(issue), .data_in(req),
        .data_out(head), .valid(head_valid), .full(in_full), .empty()
    );
    assign req_ready = ~in_full;

    // Half needs bit 0 clear, word needs both clear
    always_comb begin
        case (head.fn3[1:0])
            2'b01:   misaligned = head.addr[0];
            2'b10:   misaligned = |head.addr[1:0];
            default: misaligned = 1'b0;
        endcase
    end

    // Region decode
    assign scratch_hit = (head.addr >= SCRATCH_BASE) &&
                         (head.addr < SCRATCH_BASE + 32'(SCRATCH_WORDS * 4));
    assign slow_hit    = (head.addr >= SLOW_BASE) &&
                         (head.addr < SLOW_BASE + 32'(SLOW_WORDS * 4));
    assign error       = misaligned | ~(scratch_hit | slow_hit);
    assign offset      = head.addr - (slow_hit ? SLOW_BASE : SCRATCH_BASE);
    assign target_unit = slow_hit ? UNIT_IDX_W'(SLOW_ID) : UNIT_IDX_W'(SCRATCH_ID);

    //////////////////////////////
    // Issue control
    assign unit_ready[SCRATCH_ID] = scratch.ready;
    assign unit_ready[SLOW_ID]    = slow.ready;

    // Errors touch no unit, so no switch hazard
    assign unit_stall = ~error & (target_unit != last_unit) & ~attr_empty;
    assign issue      = head_valid & (&unit_ready) & ~unit_stall;

    always_ff @(posedge clk) begin
        if (rst)
            last_unit <= UNIT_IDX_W'(SCRATCH_ID);
        else if (issue && !error)
            last_unit <= target_unit;
    end

    // Byte enables, stores only
    always_comb begin
        case (head.fn3[1:0])
            2'b00:   be = 4'b0001 << head.addr[1:0];
            2'b01:   be = head.addr[1] ? 4'b1100 : 4'b0011;
            default: be = 4'b1111;
        endcase
        if (!head.store)
            be = 4'b0000;
    end

    // Replicate store data into every lane
    always_comb begin
        case (head.fn3[1:0])
            2'b00:   lane_data = {4{head.wdata[7:0]}};
            2'b01:   lane_data = {2{head.wdata[15:0]}};
            default: lane_data = head.wdata;
        endcase
    end

    assign unit_req.word_addr = offset[WORD_ADDR_W+1:2];
    assign unit_req.store     = head.store;
    assign unit_req.be        = be;
    assign unit_req.wdata     = lane_data;

    assign scratch.req         = unit_req;
    assign slow.req            = unit_req;
    assign scratch.new_request = issue & ~error & scratch_hit;
    assign slow.new_request    = issue & ~error & slow_hit;

    //////////////////////////////
    // Attribute queue
    assign attr_in.fn3       = head.fn3;
    assign attr_in.byte_addr = head.addr[1:0];
    assign attr_in.id        = head.id;
    assign attr_in.store     = head.store;
    assign attr_in.error     = error;

    ls_fifo #(.item_t(load_attr_t), .DEPTH(ATTR_DEPTH)) i_attr_fifo (
        .clk(clk), .rst(rst),
        .push(issue), .pop(resp_valid), .data_in(attr_in),
        .data_out(attr_head), .valid(attr_valid), .full(), .empty(attr_empty)
    );

    //////////////////////////////
    // Load return path
    assign load_complete = scratch.data_valid | slow.data_valid;
    assign unit_data     = scratch.data_out | slow.data_out;

    // Halfword first, then byte
    always_comb begin
        aligned        = unit_data;
        aligned[15:0]  = attr_head.byte_addr[1] ? unit_data[31:16] : unit_data[15:0];
        aligned[7:0]   = attr_head.byte_addr[0] ? aligned[15:8] : aligned[7:0];
    end

    always_comb begin
        case (attr_head.fn3)
            LS_B:    final_data = {{24{aligned[7]}}, aligned[7:0]};
            LS_H:    final_data = {{16{aligned[15]}}, aligned[15:0]};
            LS_BU:   final_data = {24'h0, aligned[7:0]};
            LS_HU:   final_data = {16'h0, aligned[15:0]};
            default: final_data = aligned;
        endcase
    end

    // Stores and errors finish the cycle after issue
    assign resp_valid = load_complete | (attr_valid & (attr_head.store | attr_head.error));
    assign resp_id    = attr_head.id;
    assign resp_data  = final_data;
    assign resp_error = attr_head.error;

endmodule

`default_nettype wire

/* ls_top.sv */
//////////////////////////////
// Load/store subsystem top level
//////////////////////////////
`default_nettype none

module ls_top import ls_pkg::*; (
    input  wire logic        clk,
    input  wire logic        rst,
    input  wire logic        req_valid,
    input  wire logic        req_store,
    input  wire logic [2:0]  req_fn3,
    input  wire logic [31:0] req_addr,
    input  wire logic [31:0] req_wdata,
    input  wire ls_id_t      req_id,
    output logic             req_ready,
    output logic             resp_valid,
    output ls_id_t           resp_id,
    output logic [31:0]      resp_data,
    output logic             resp_error
);

    ls_request_t   req;
    ls_sub_unit_if scratch_if ();
    ls_sub_unit_if slow_if ();

    // Pack the plain request ports
    assign req.store = req_store;
    assign req.fn3   = ls_fn3_e'(req_fn3);
    assign req.addr  = req_addr;
    assign req.wdata = req_wdata;
    assign req.id    = req_id;

    load_store_unit i_load_store_unit (
        .clk        (clk),
        .rst        (rst),
        .req_valid  (req_valid),
        .req_ready  (req_ready),
        .req        (req),
        .scratch    (scratch_if.core),
        .slow       (slow_if.core),
        .resp_valid (resp_valid),
        .resp_id    (resp_id),
        .resp_data  (resp_data),
        .resp_error (resp_error)
    );

    scratch_mem i_scratch_mem (.clk(clk), .rst(rst), .ls(scratch_if.unit));

    slow_mem_ctrl i_slow_mem_ctrl (.clk(clk), .rst(rst), .ls(slow_if.unit));

endmodule

`default_nettype wire

/* ls_asserts.sv */
//////////////////////////////
// Protocol assertions for the unit core
//////////////////////////////
`default_nettype none

module ls_asserts (
    input wire logic clk,
    input wire logic rst,
    input wire logic slow_new,
    input wire logic slow_ready,
    input wire logic attr_push,
    input wire logic attr_full,
    input wire logic attr_empty,
    input wire logic resp_valid
);

    timeunit 1ns;
    timeprecision 100ps;

    // Sub-unit handshake
    a_slow_ready: assert property (@(posedge clk) disable iff (rst)
        slow_new |-> slow_ready)
        else $error("Slow unit got new_request while not ready");

    // Push into a full attribute queue would be dropped
    a_attr_overflow: assert property (@(posedge clk) disable iff (rst)
        attr_push |-> !attr_full)
        else $error("Attribute queue pushed while full");

    a_resp_needs_attr: assert property (@(posedge clk) disable iff (rst)
        resp_valid |-> !attr_empty)
        else $error("Completion with empty attribute queue");

endmodule

bind load_store_unit ls_asserts i_ls_asserts (
    .clk           (clk),
    .rst           (rst),
    .slow_new      (slow.new_request),
    .slow_ready    (slow.ready),
    .attr_push     (issue),
    .attr_full     (i_attr_fifo.full),
    .attr_empty    (attr_empty),
    .resp_valid    (resp_valid)
);

`default_nettype wire

/* tb_ls_top.sv */
//////////////////////////////
// Testbench for the load/store subsystem
// File-driven requests and in-order completion checks
//////////////////////////////
`default_nettype none

module tb_ls_top;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int MAX_REQS     = 64;
    localparam int FIELDS       = 7;
    localparam int TIMEOUT      = 200;
    localparam int QUIET_CYCLES = 16;

    logic        clk;
    logic        rst;
    logic        req_valid;
    logic        req_store;
    logic [2:0]  req_fn3;
    logic [31:0] req_addr;
    logic [31:0] req_wdata;
    logic [3:0]  req_id;
    logic        req_ready;
    logic        resp_valid;
    logic [3:0]  resp_id;
    logic [31:0] resp_data;
    logic        resp_error;

    // FIELDS words per request in data file column order
    logic [31:0] stim [FIELDS*MAX_REQS];
    int          num_reqs;
    int          exp_q [$];
    logic [31:0] rand_state;

    ls_top i_ls_top (
        .clk        (clk),
        .rst        (rst),
        .req_valid  (req_valid),
        .req_store  (req_store),
        .req_fn3    (req_fn3),
        .req_addr   (req_addr),
        .req_wdata  (req_wdata),
        .req_id     (req_id),
        .req_ready  (req_ready),
        .resp_valid (resp_valid),
        .resp_id    (resp_id),
        .resp_data  (resp_data),
        .resp_error (resp_error)
    );

    // 8 ns clock
    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Regression failed");
        $fatal(1, "Stopped at first error");
    endtask

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    //////////////////////////////
    // Request driver on the falling edge
    task automatic drive_requests();
        int gap;
        int waited;
        for (int i = 0; i < num_reqs; i++) begin
            // Idle gap of 0 to 3 cycles
            rand_state = lcg_next(rand_state);
            gap = int'(rand_state[31:30]);
            repeat (gap) begin
                @(negedge clk);
                req_valid = 1'b0;
            end
            @(negedge clk);
            req_valid = 1'b1;
            req_store = stim[FIELDS*i][0];
            req_fn3   = stim[FIELDS*i+1][2:0];
            req_addr  = stim[FIELDS*i+2];
            req_wdata = stim[FIELDS*i+3];
            req_id    = stim[FIELDS*i+4][3:0];
            // Hold under back-pressure
            waited = 0;
            while (!req_ready) begin
                assert (waited < TIMEOUT)
                    else report_failure($sformatf(
                        "Timeout waiting for req_ready, request %0d", i));
                @(negedge clk);
                waited++;
            end
            // Accepted at the coming rising edge
            exp_q.push_back(i);
        end
        @(negedge clk);
        req_valid = 1'b0;
    endtask

    //////////////////////////////
    // Completion checker
    task automatic check_completion(input int idx);
        logic [3:0]  exp_id;
        logic        exp_err;
        logic [31:0] exp_data;
        logic        is_load;
        exp_id   = stim[FIELDS*idx+4][3:0];
        exp_err  = stim[FIELDS*idx+5][0];
        exp_data = stim[FIELDS*idx+6];
        is_load  = ~stim[FIELDS*idx][0];
        assert (resp_id == exp_id)
            else report_failure($sformatf(
                "Mismatch resp_id: got 0x%h, expected 0x%h (request %0d)",
                resp_id, exp_id, idx));
        assert (resp_error == exp_err)
            else report_failure($sformatf(
                "Mismatch resp_error: got 0x%h, expected 0x%h (request %0d)",
                resp_error, exp_err, idx));
        // Data only means something for good loads
        if (is_load && !exp_err) begin
            assert (resp_data == exp_data)
                else report_failure($sformatf(
                    "Mismatch resp_data: got 0x%h, expected 0x%h (request %0d)",
                    resp_data, exp_data, idx));
        end
    endtask

    task automatic collect_responses();
        int waited;
        for (int k = 0; k < num_reqs; k++) begin
            waited = 0;
            @(negedge clk);
            while (!resp_valid) begin
                assert (waited < TIMEOUT)
                    else report_failure($sformatf(
                        "No completion arrived for request %0d", k));
                @(negedge clk);
                waited++;
            end
            assert (exp_q.size() > 0)
                else report_failure("A completion arrived with no request outstanding");
            check_completion(exp_q.pop_front());
        end
    endtask

    //////////////////////////////
    // Main sequence
    initial begin
        rst        = 1'b1;
        req_valid  = 1'b0;
        req_store  = 1'b0;
        req_fn3    = 3'h0;
        req_addr   = 32'h0;
        req_wdata  = 32'h0;
        req_id     = 4'h0;
        rand_state = 32'h99cf;

        // All ones in the store column marks the end of the list
        for (int i = 0; i < FIELDS*MAX_REQS; i++)
            stim[i] = 32'hffff_ffff;
        $readmemh("ls_input.txt", stim);
        num_reqs = 0;
        while (num_reqs < MAX_REQS && stim[FIELDS*num_reqs] != 32'hffff_ffff)
            num_reqs++;
        assert (num_reqs > 0) else report_failure("No requests found in ls_input.txt");

        repeat (8) @(posedge clk);
        @(negedge clk);
        assert (req_ready && !resp_valid)
            else report_failure("Port state after reset is wrong");
        rst = 1'b0;

        fork
            drive_requests();
            collect_responses();
        join

        // Nothing more may complete
        repeat (QUIET_CYCLES) begin
            @(negedge clk);
            assert (!resp_valid)
                else report_failure("A completion appeared after the last request finished");
        end

        $display("Regression passed");
        $finish;
    end

endmodule

`default_nettype wire

/* ls_input.txt */
// Columns, hex: store fn3 addr wdata id, then expected error and load data
// fn3: 0 byte, 1 half, 2 word, 4 byte unsigned, 5 half unsigned
1 2 00000010 11223344 0 0 00000000
1 2 00010020 a5a55a5a 1 0 00000000
0 2 00000010 00000000 2 0 11223344
0 2 00010020 00000000 3 0 a5a55a5a
1 0 00000011 000000ee 4 0 00000000
1 0 00000013 00000099 5 0 00000000
1 0 00000010 12345677 6 0 00000000
1 0 00000012 abcdef01 7 0 00000000
0 2 00000010 00000000 8 0 9901ee77
1 1 00010022 0000c0de 9 0 00000000
1 1 00010020 ffff1234 a 0 00000000
0 2 00010020 00000000 b 0 c0de1234
0 0 00000010 00000000 c 0 00000077
0 0 00000011 00000000 d 0 ffffffee
0 4 00000011 00000000 e 0 000000ee
0 0 00000013 00000000 f 0 ffffff99
0 4 00000012 00000000 0 0 00000001
0 1 00000010 00000000 1 0 ffffee77
0 5 00000012 00000000 2 0 00009901
0 1 00010022 00000000 3 0 ffffc0de
0 5 00010020 00000000 4 0 00001234
0 0 00010023 00000000 5 0 ffffffc0
0 4 00010021 00000000 6 0 00000012
1 2 00000012 deadbeef 7 1 00000000
1 1 00010021 0000ffff 8 1 00000000
0 2 00000011 00000000 9 1 00000000
0 1 00000013 00000000 a 1 00000000
1 2 00002000 00000000 b 1 00000000
0 2 00010400 00000000 c 1 00000000
0 2 00000010 00000000 d 0 9901ee77
0 2 00010020 00000000 e 0 c0de1234
1 2 00000100 0badf00d f 0 00000000
1 2 00010100 600dcafe 0 0 00000000
0 2 00000100 00000000 1 0 0badf00d
0 2 00010100 00000000 2 0 600dcafe

/* project.f */
ls_pkg.sv
ls_sub_unit_if.sv
ls_fifo.sv
scratch_mem.sv
wait_timer.sv
slow_mem_ctrl.sv
load_store_unit.sv
ls_top.sv
ls_asserts.sv
tb_ls_top.sv

/* Bender.yml */
package:
  name: ls_subsystem

sources:
  - ls_pkg.sv
  - ls_sub_unit_if.sv
  - ls_fifo.sv
  - scratch_mem.sv
  - wait_timer.sv
  - slow_mem_ctrl.sv
  - load_store_unit.sv
  - ls_top.sv
  - target: test
    files:
      - ls_asserts.sv
      - tb_ls_top.sv
